//--- hdl/cpuPkg.sv
`default_nettype none

package cpuPkg;

	// Datapath and memory sizes
	localparam int WORD_W    = 16;
	localparam int ADDR_W    = 8;
	localparam int NUM_REGS  = 4;
	localparam int MEM_WORDS = 256;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [1:0]        regIdx_t;

	// Register contents seen from outside the core
	typedef word_t [NUM_REGS-1:0] regBank_t;

	// Instruction field positions
	localparam int OPC_HI = 15;
	localparam int OPC_LO = 12;
	localparam int RD_HI  = 11;
	localparam int RD_LO  = 10;
	localparam int RS1_HI = 9;
	localparam int RS1_LO = 8;
	localparam int RS2_HI = 7;
	localparam int RS2_LO = 6;
	localparam int IMM_HI = 7;
	localparam int IMM_LO = 0;

	// Codes 8 to 15 are treated as no-ops
	typedef enum logic [3:0] {
		ADD  = 4'd0,
		NAND = 4'd1,
		LD   = 4'd2,
		LDR  = 4'd3,
		ST   = 4'd4,
		STR  = 4'd5,
		BZ   = 4'd6,
		JR   = 4'd7
	} opcode_t;

	typedef enum logic [1:0] {
		INCR = 2'd0,
		REL  = 2'd1,
		REG  = 2'd2
	} pcSel_t;

	typedef struct packed {
		pcSel_t  pcSel;
		logic    regWe;
		regIdx_t rd;
		regIdx_t rs1;
		regIdx_t rs2;
		logic    aluOp;        // Nand when set
		logic    flagEn;
		logic    wbFromMem;
		logic    memWe;
		logic    dAddrFromReg;
		word_t   offset;
	} ctrl_t;

endpackage

`default_nettype wire

//--- hdl/memory.sv
`timescale 1ns/1ps
`default_nettype none

module memory (
	input  logic          clk,

	// Instruction fetch
	input  cpuPkg::addr_t iAddr,
	output cpuPkg::word_t iData,

	// Load/store port
	input  cpuPkg::addr_t dAddr,
	input  logic          dWe,
	input  cpuPkg::word_t dDataIn,
	output cpuPkg::word_t dDataOut,

	// Host program loading
	input  logic          loadEn,
	input  cpuPkg::addr_t loadAddr,
	input  cpuPkg::word_t loadData,

	// Debug observation
	input  cpuPkg::addr_t peekAddr,
	output cpuPkg::word_t peekData
);

	import cpuPkg::*;

	word_t mem [0:MEM_WORDS-1];

	// One write per edge, the core has priority over the host
	always_ff @(posedge clk) begin
		if (dWe) begin
			mem[dAddr] <= dDataIn;
		end
		else if (loadEn) begin
			mem[loadAddr] <= loadData;
		end
	end

	// Asynchronous reads on all three ports
	assign iData    = mem[iAddr];
	assign dDataOut = mem[dAddr];
	assign peekData = mem[peekAddr];

endmodule

`default_nettype wire

//--- hdl/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile (
	input  logic            clk,
	input  logic            rst,

	// Write port
	input  logic            we,
	input  cpuPkg::regIdx_t inReg,
	input  cpuPkg::word_t   dataIn,

	// Read ports
	input  cpuPkg::regIdx_t outReg1,
	input  cpuPkg::regIdx_t outReg2,
	output cpuPkg::word_t   dataOut1,
	output cpuPkg::word_t   dataOut2,

	// All registers at once
	output cpuPkg::regBank_t snapshot
);

	import cpuPkg::*;

	regBank_t regs;

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			regs <= '0;
		end
		else if (we) begin
			regs[inReg] <= dataIn;
		end
	end

	// No write bypass, a read sees the value from before the edge
	assign dataOut1 = regs[outReg1];
	assign dataOut2 = regs[outReg2];

	assign snapshot = regs;

endmodule

`default_nettype wire

//--- hdl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  logic          clk,
	input  logic          rst,
	input  cpuPkg::word_t in1,
	input  cpuPkg::word_t in2,
	input  logic          op,
	input  logic          flagEn,
	output cpuPkg::word_t result,
	output logic          zFlag
);

	import cpuPkg::*;

	word_t sum;
	word_t nandOut;

	assign sum     = in1 + in2;
	assign nandOut = ~(in1 & in2);

	// op set selects nand
	assign result = op ? nandOut : sum;

	// Flag only follows ALU instructions, loads and stores leave it alone
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			zFlag <= 1'b0;
		end
		else if (flagEn) begin
			zFlag <= (result == '0);
		end
	end

endmodule

`default_nettype wire

//--- hdl/decoder.sv
`timescale 1ns/1ps
`default_nettype none

module decoder (
	input  cpuPkg::word_t instruction,
	input  logic          zFlag,
	output cpuPkg::ctrl_t ctrl
);

	import cpuPkg::*;

	opcode_t              opcode;
	logic [IMM_HI:IMM_LO] imm8;

	assign opcode = opcode_t'(instruction[OPC_HI:OPC_LO]);
	assign imm8   = instruction[IMM_HI:IMM_LO];

	always_comb begin
		// Safe defaults give a no-op
		ctrl              = '0;
		ctrl.pcSel        = INCR;
		ctrl.rd           = instruction[RD_HI:RD_LO];
		ctrl.rs1          = instruction[RS1_HI:RS1_LO];
		ctrl.rs2          = instruction[RS2_HI:RS2_LO];
		ctrl.offset       = {{(WORD_W - 8){imm8[7]}}, imm8};

		case (opcode)
			ADD: begin
				ctrl.regWe  = 1'b1;
				ctrl.flagEn = 1'b1;
				ctrl.aluOp  = 1'b0;
			end

			NAND: begin
				ctrl.regWe  = 1'b1;
				ctrl.flagEn = 1'b1;
				ctrl.aluOp  = 1'b1;
			end

			// Loads write back from the data port
			LD: begin
				ctrl.regWe     = 1'b1;
				ctrl.wbFromMem = 1'b1;
			end

			LDR: begin
				ctrl.regWe        = 1'b1;
				ctrl.wbFromMem    = 1'b1;
				ctrl.dAddrFromReg = 1'b1;
			end

			// Stores always take their data from rs2
			ST: begin
				ctrl.memWe = 1'b1;
			end

			STR: begin
				ctrl.memWe        = 1'b1;
				ctrl.dAddrFromReg = 1'b1;
			end

			BZ: begin
				if (zFlag) begin
					ctrl.pcSel = REL;
				end
			end

			JR: begin
				ctrl.pcSel = REG;
			end

			default: begin
				ctrl.pcSel = INCR;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/processor.sv
`timescale 1ns/1ps
`default_nettype none

module processor (
	input  logic             clk,
	input  logic             rst,
	input  logic             run,

	// Host load port, only honoured while stopped
	input  logic             loadEn,
	input  cpuPkg::addr_t    loadAddr,
	input  cpuPkg::word_t    loadData,

	// Observation
	input  cpuPkg::addr_t    peekAddr,
	output cpuPkg::word_t    peekData,
	output cpuPkg::word_t    pc,
	output cpuPkg::regBank_t regs,
	output logic [7:0]       led
);

	import cpuPkg::*;

	ctrl_t ctrl;
	word_t instruction;
	word_t rs1Data;
	word_t rs2Data;
	word_t aluResult;
	word_t memData;
	word_t wbData;
	word_t nextPc;
	addr_t dAddr;
	logic  zFlag;

	// Nothing architectural changes while the core is stopped
	logic regWeRun;
	logic memWeRun;
	logic flagEnRun;
	logic hostWe;

	assign regWeRun  = ctrl.regWe & run;
	assign memWeRun  = ctrl.memWe & run;
	assign flagEnRun = ctrl.flagEn & run;
	assign hostWe    = loadEn & ~run;

	memory mem (
		.clk      (clk),
		.iAddr    (pc[ADDR_W-1:0]),
		.iData    (instruction),
		.dAddr    (dAddr),
		.dWe      (memWeRun),
		.dDataIn  (rs2Data),
		.dDataOut (memData),
		.loadEn   (hostWe),
		.loadAddr (loadAddr),
		.loadData (loadData),
		.peekAddr (peekAddr),
		.peekData (peekData)
	);

	registerFile regFile (
		.clk      (clk),
		.rst      (rst),
		.we       (regWeRun),
		.inReg    (ctrl.rd),
		.dataIn   (wbData),
		.outReg1  (ctrl.rs1),
		.outReg2  (ctrl.rs2),
		.dataOut1 (rs1Data),
		.dataOut2 (rs2Data),
		.snapshot (regs)
	);

	alu aluUnit (
		.clk    (clk),
		.rst    (rst),
		.in1    (rs1Data),
		.in2    (rs2Data),
		.op     (ctrl.aluOp),
		.flagEn (flagEnRun),
		.result (aluResult),
		.zFlag  (zFlag)
	);

	decoder decode (
		.instruction (instruction),
		.zFlag       (zFlag),
		.ctrl        (ctrl)
	);

	// Writeback and data address selection
	assign wbData = ctrl.wbFromMem ? memData : aluResult;
	assign dAddr  = ctrl.dAddrFromReg ? rs1Data[ADDR_W-1:0] : ctrl.offset[ADDR_W-1:0];

	always_comb begin
		case (ctrl.pcSel)
			REG:     nextPc = rs1Data;
			REL:     nextPc = pc + ctrl.offset;
			default: nextPc = pc + word_t'(1);
		endcase
	end

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			pc <= '0;
		end
		else if (run) begin
			pc <= nextPc;
		end
	end

	assign led = pc[7:0];

endmodule

`default_nettype wire

//--- sim/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen (
	output logic clk,
	output logic rst
);

	localparam int HALF_PERIOD  = 4;
	localparam int RESET_CYCLES = 2;

	// 8 ns period
	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

`default_nettype wire

//--- sim/processorTb.sv
`timescale 1ns/1ps
`default_nettype none

module processorTb;

	import cpuPkg::*;

	localparam CASES_FILE = "sim/processor_cases.txt";
	localparam int RESET_LIMIT = 16;
	localparam int MAX_RUN     = 200;

	// A word to load, or a register or address with its expected value
	typedef struct packed {
		logic [15:0] key;
		word_t       value;
	} entry_t;

	logic       clk;
	logic       genRst;
	logic       caseRst;
	logic       rst;
	logic       run;
	logic       loadEn;
	addr_t      loadAddr;
	word_t      loadData;
	addr_t      peekAddr;
	word_t      peekData;
	word_t      pc;
	regBank_t   regs;
	logic [7:0] led;

	entry_t loadQ[$];
	entry_t regQ[$];
	entry_t memQ[$];
	int     runLen;
	word_t  expectedPc;
	string  caseName;
	int     errors;
	int     checks;
	bit     aborted;

	clockGen clocks (.clk(clk), .rst(genRst));

	assign rst = genRst | caseRst;

	processor DUT (
		.clk      (clk),
		.rst      (rst),
		.run      (run),
		.loadEn   (loadEn),
		.loadAddr (loadAddr),
		.loadData (loadData),
		.peekAddr (peekAddr),
		.peekData (peekData),
		.pc       (pc),
		.regs     (regs),
		.led      (led)
	);

	task automatic checkValue(input string name, input word_t actual, input word_t expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAILED %s in case %s: got %h, expected %h", name, caseName, actual, expected);
		end
	endtask

	task automatic waitResetRelease();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (rst && cycles < RESET_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		if (rst) begin
			$display("ERROR: reset still active after %0d cycles", RESET_LIMIT);
			errors++;
			aborted = 1'b1;
		end
	endtask

	task automatic pulseReset();
		@(posedge clk);
		caseRst <= 1'b1;
		run     <= 1'b0;
		loadEn  <= 1'b0;
		repeat (2) @(posedge clk);
		caseRst <= 1'b0;
	endtask

	// Core stopped, so PC, led and registers must all still be zero
	task automatic checkIdle(input string when);
		checkValue($sformatf("pc (%s)", when), pc, '0);
		checkValue($sformatf("led (%s)", when), {8'h00, led}, '0);
		for (int i = 0; i < NUM_REGS; i++) begin
			checkValue($sformatf("regs[%0d] (%s)", i, when), regs[regIdx_t'(i)], '0);
		end
	endtask

	task automatic peekCheck(input addr_t addr, input word_t expected);
		@(posedge clk);
		peekAddr <= addr;
		@(negedge clk);
		checkValue($sformatf("peekData[%02h]", addr), peekData, expected);
	endtask

	task automatic loadWords();
		foreach (loadQ[i]) begin
			@(posedge clk);
			loadEn   <= 1'b1;
			loadAddr <= loadQ[i].key[7:0];
			loadData <= loadQ[i].value;
		end
		@(posedge clk);
		loadEn <= 1'b0;
	endtask

	// One instruction per cycle while run is high
	task automatic runCore();
		if (runLen > MAX_RUN) begin
			$display("ERROR: case %s asks for %0d cycles, more than %0d", caseName, runLen, MAX_RUN);
			errors++;
		end
		else if (runLen > 0) begin
			@(posedge clk);
			run <= 1'b1;
			repeat (runLen) @(posedge clk);
			run <= 1'b0;
		end
	endtask

	task automatic executeCase();
		$display("Case %s", caseName);
		pulseReset();
		waitResetRelease();
		if (!aborted) begin
			checkIdle("after reset");
			loadWords();
			@(negedge clk);
			checkIdle("after load");
			foreach (loadQ[i]) peekCheck(loadQ[i].key[7:0], loadQ[i].value);
			runCore();
			@(negedge clk);
			foreach (regQ[i]) begin
				checkValue($sformatf("regs[%0d]", regQ[i].key), regs[regQ[i].key[1:0]],
					regQ[i].value);
			end
			checkValue("pc", pc, expectedPc);
			checkValue("led", {8'h00, led}, {8'h00, expectedPc[7:0]});
			foreach (memQ[i]) peekCheck(memQ[i].key[7:0], memQ[i].value);
		end
	endtask

	task automatic handleLine(input string line);
		byte         tag;
		logic [31:0] a;
		logic [31:0] b;
		entry_t      e;
		tag = line[0];
		a = '0;
		b = '0;
		if (line.len() > 1) begin
			void'($sscanf(line.substr(1, line.len() - 1), "%h %h", a, b));
		end
		e = {a[15:0], b[15:0]};
		case (tag)
			"C": begin
				caseName = (line.len() > 2) ? line.substr(2, line.len() - 1) : "unnamed";
				loadQ.delete();
				regQ.delete();
				memQ.delete();
				runLen     = 0;
				expectedPc = '0;
			end
			"P": loadQ.push_back(e);
			"N": runLen = int'(a);
			"R": regQ.push_back(e);
			"M": memQ.push_back(e);
			"Q": expectedPc = a[15:0];
			"E": executeCase();
			default: begin
				$display("ERROR: unknown line in cases file: %s", line);
				errors++;
			end
		endcase
	endtask

	function automatic string stripLineEnd(input string s);
		string t;
		t = s;
		while (t.len() > 0 && (t[t.len() - 1] == 8'h0a || t[t.len() - 1] == 8'h0d)) begin
			t = t.substr(0, t.len() - 2);
		end
		return t;
	endfunction

	initial begin
		int    fd;
		int    status;
		string line;
		caseRst    = 1'b0;
		run        = 1'b0;
		loadEn     = 1'b0;
		loadAddr   = '0;
		loadData   = '0;
		peekAddr   = '0;
		errors     = 0;
		checks     = 0;
		aborted    = 1'b0;
		runLen     = 0;
		expectedPc = '0;
		caseName   = "none";
		fd = $fopen(CASES_FILE, "r");
		if (fd == 0) begin
			$display("ERROR: could not open %s", CASES_FILE);
			errors++;
		end
		else begin
			waitResetRelease();
			while (!aborted && !$feof(fd)) begin
				status = $fgets(line, fd);
				line = stripLineEnd(line);
				if (status != 0 && line.len() > 0 && line[0] != "#") begin
					handleLine(line);
				end
			end
			$fclose(fd);
		end
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end
		else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/processor_cases.txt
# C name | P addr word | N cycles | R reg value | M addr value | Q pc | E  (numbers in hex)
# Instruction word: op[15:12] rd[11:10] rs1[9:8] rs2[7:6] imm8[7:0]
C alu_add_nand
P 00 2420
P 01 2821
P 02 0d80
P 03 1180
P 04 0b00
P 20 1234
P 21 0f0f
N 5
R 0 fdfb
R 1 1234
R 2 1f3e
R 3 2143
Q 0005
E
C store_load
P 00 2430
P 01 2831
P 02 4044
P 03 1d40
P 04 52c0
P 05 3200
P 06 2844
P 30 00a5
P 31 0050
P 44 dead
P 50 beef
N 7
R 0 ff5a
R 2 00a5
R 3 ff5a
M 44 00a5
M 50 ff5a
Q 0007
E
C branch_zero
P 00 2420
P 01 2821
P 02 0d80
P 03 2020
P 04 6002
P 05 1000
P 06 0040
P 07 60f8
P 08 0a80
P 20 0001
P 21 ffff
N 8
R 0 0002
R 2 fffe
R 3 0000
Q 0009
E
C jump_loop
P 00 2420
P 01 2c21
P 02 0040
P 03 7300
P 20 0001
P 21 0002
N 9
R 0 0004
R 3 0002
Q 0003
E
C hold_while_stopped
P 00 1000
P 80 1357
N 0
M 80 1357
Q 0000
E

//--- compile.f
hdl/cpuPkg.sv
hdl/memory.sv
hdl/registerFile.sv
hdl/alu.sv
hdl/decoder.sv
hdl/processor.sv
sim/clockGen.sv
sim/processorTb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps -f compile.f --top-module processorTb \
	-Mdir obj_dir -o processorSim || { echo "Build failed"; exit 1; }
out=$(./obj_dir/processorSim)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qxF '=== PASS ===' && exit 0 || { echo "Simulation failed"; exit 1; }
